// ==== cfg_pkg.sv ====
package cfg_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // sizes and constants
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    localparam int NUM_CH = 4;
    localparam int CH_BITS = 2;

    // address layout: register index in bits 3:1, channel in bits 5:4
    localparam int ADDR_REG_LSB = 1;
    localparam int ADDR_CH_LSB = 4;

    localparam logic [31:0] CFG_VERSION = 32'h0002_0107;

    // same order as the register map seen by the host
    typedef enum logic [2:0] {
        REG_STATUS,
        REG_COMMAND,
        REG_DATA_0_H,
        REG_DATA_0_L,
        REG_DATA_1_H,
        REG_DATA_1_L,
        REG_VERSION_H,
        REG_VERSION_L
    } reg_idx_e;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // bus and port bundles
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef struct packed {
        logic [15:0] address;
        logic        write;
        logic [15:0] wdata;
    } host_bus_t;

    // write as seen by one channel
    typedef struct packed {
        logic        write;
        reg_idx_e    reg_sel;
        logic [15:0] wdata;
    } ch_wr_t;

    typedef struct packed {
        logic               valid;
        logic [CH_BITS-1:0] ch;
        logic [7:0]         cmd;
        logic [31:0]        arg0;
        logic [31:0]        arg1;
    } ctrl_req_t;

    typedef struct packed {
        logic        done;
        logic        error;
        logic        irq;
        logic [31:0] res0;
        logic [31:0] res1;
    } ctrl_rsp_t;

    // completion payload fanned out to every channel
    typedef struct packed {
        logic        error;
        logic        irq;
        logic [31:0] res0;
        logic [31:0] res1;
    } mbox_rsp_t;

    typedef struct packed {
        logic        pending;
        logic [7:0]  cmd;
        logic [31:0] arg0;
        logic [31:0] arg1;
    } mbox_cmd_t;

endpackage

// ==== cfg_bus_decode.sv ====
`timescale 1ns/1ps

module cfg_bus_decode (
    input  cfg_pkg::host_bus_t bus,

    output cfg_pkg::ch_wr_t    ch_wr [cfg_pkg::NUM_CH],
    output cfg_pkg::reg_idx_e  ch_reg,

    input  logic [15:0]        ch_rdata [cfg_pkg::NUM_CH],
    output logic [15:0]        rdata
);

    cfg_pkg::reg_idx_e           reg_idx;
    logic [cfg_pkg::CH_BITS-1:0] ch_idx;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // address split
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign reg_idx = cfg_pkg::reg_idx_e'(bus.address[cfg_pkg::ADDR_REG_LSB +: 3]);
    assign ch_idx = bus.address[cfg_pkg::ADDR_CH_LSB +: cfg_pkg::CH_BITS];

    // register index goes to every channel, reads are muxed below
    assign ch_reg = reg_idx;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // write steering
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        for (int i = 0; i < cfg_pkg::NUM_CH; i++) begin
            // only the addressed channel sees the strobe
            ch_wr[i].write = bus.write && (ch_idx == cfg_pkg::CH_BITS'(i));
            ch_wr[i].reg_sel = reg_idx;
            ch_wr[i].wdata = bus.wdata;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // read return
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // combinational, host samples in the same cycle as the address
    always_comb begin
        rdata = 16'h0000;
        for (int i = 0; i < cfg_pkg::NUM_CH; i++) begin
            if (ch_idx == cfg_pkg::CH_BITS'(i)) begin
                rdata = ch_rdata[i];
            end
        end
    end

endmodule

// ==== cfg_mailbox.sv ====
`timescale 1ns/1ps

module cfg_mailbox (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               host_reset,

    input  cfg_pkg::ch_wr_t    wr,
    input  cfg_pkg::reg_idx_e  rd_reg,
    output logic [15:0]        rdata,

    output cfg_pkg::mbox_cmd_t offer,

    input  logic               done,
    input  logic               rsp_error,
    input  logic               rsp_irq,
    input  logic [31:0]        res0,
    input  logic [31:0]        res1,

    output logic               irq
);

    logic        pending;
    logic        error;
    logic [7:0]  cmd;
    logic [31:0] arg0;
    logic [31:0] arg1;
    logic [31:0] res0_q;
    logic [31:0] res1_q;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // control flags
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pending <= 1'b0;
            cmd <= 8'h00;
            error <= 1'b0;
            irq <= 1'b0;
        end else if (host_reset) begin
            // console reset, error is left alone
            pending <= 1'b0;
            cmd <= 8'h00;
            irq <= 1'b0;
        end else begin
            if (done) begin
                pending <= 1'b0;
                error <= rsp_error;
                if (rsp_irq) begin
                    irq <= 1'b1;
                end
            end

            // host write comes after done so a new command or an irq clear wins
            if (wr.write) begin
                case (wr.reg_sel)
                    cfg_pkg::REG_COMMAND: begin
                        pending <= 1'b1;
                        cmd <= wr.wdata[7:0];
                    end
                    cfg_pkg::REG_VERSION_L: irq <= 1'b0;
                    default: ;
                endcase
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // argument and result words
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk) begin
        if (wr.write) begin
            case (wr.reg_sel)
                cfg_pkg::REG_DATA_0_H: arg0[31:16] <= wr.wdata;
                cfg_pkg::REG_DATA_0_L: arg0[15:0] <= wr.wdata;
                cfg_pkg::REG_DATA_1_H: arg1[31:16] <= wr.wdata;
                cfg_pkg::REG_DATA_1_L: arg1[15:0] <= wr.wdata;
                default: ;
            endcase
        end

        if (done) begin
            res0_q <= res0;
            res1_q <= res1;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // host read side
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // data registers read back the results, not the arguments
    always_comb begin
        rdata = 16'h0000;
        case (rd_reg)
            cfg_pkg::REG_STATUS:    rdata = {pending, error, 14'd0};
            cfg_pkg::REG_COMMAND:   rdata = {8'h00, cmd};
            cfg_pkg::REG_DATA_0_H:  rdata = res0_q[31:16];
            cfg_pkg::REG_DATA_0_L:  rdata = res0_q[15:0];
            cfg_pkg::REG_DATA_1_H:  rdata = res1_q[31:16];
            cfg_pkg::REG_DATA_1_L:  rdata = res1_q[15:0];
            cfg_pkg::REG_VERSION_H: rdata = cfg_pkg::CFG_VERSION[31:16];
            cfg_pkg::REG_VERSION_L: rdata = cfg_pkg::CFG_VERSION[15:0];
            default: ;
        endcase
    end

    assign offer.pending = pending;
    assign offer.cmd = cmd;
    assign offer.arg0 = arg0;
    assign offer.arg1 = arg1;

endmodule

// ==== cfg_cmd_arbiter.sv ====
`timescale 1ns/1ps

module cfg_cmd_arbiter (
    input  logic                        clk,
    input  logic                        arst_n,
    input  logic                        host_reset,

    input  cfg_pkg::mbox_cmd_t          offer [cfg_pkg::NUM_CH],
    output logic [cfg_pkg::NUM_CH-1:0]  ch_done,
    output cfg_pkg::mbox_rsp_t          rsp_fwd,

    output cfg_pkg::ctrl_req_t          req,
    input  cfg_pkg::ctrl_rsp_t          rsp
);

    logic                        busy;
    logic [cfg_pkg::CH_BITS-1:0] grant;
    logic [cfg_pkg::CH_BITS-1:0] next_ch;
    logic                        found;
    logic [7:0]                  req_cmd;
    logic [31:0]                 req_arg0;
    logic [31:0]                 req_arg1;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // round-robin search
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // start one past the last grant, the last grant itself is checked last
    always_comb begin
        int idx;
        found = 1'b0;
        next_ch = grant;
        for (int k = 1; k <= cfg_pkg::NUM_CH; k++) begin
            idx = (int'(grant) + k) % cfg_pkg::NUM_CH;
            if (!found && offer[idx].pending) begin
                found = 1'b1;
                next_ch = cfg_pkg::CH_BITS'(idx);
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // grant state
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            busy <= 1'b0;
            grant <= cfg_pkg::CH_BITS'(cfg_pkg::NUM_CH - 1);
        end else if (host_reset) begin
            // outstanding request is dropped
            busy <= 1'b0;
        end else if (busy) begin
            if (rsp.done) begin
                busy <= 1'b0;
            end
        end else if (found) begin
            busy <= 1'b1;
            grant <= next_ch;
        end
    end

    // request payload is frozen while busy
    always_ff @(posedge clk) begin
        if (!busy && found) begin
            req_cmd <= offer[next_ch].cmd;
            req_arg0 <= offer[next_ch].arg0;
            req_arg1 <= offer[next_ch].arg1;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // controller port and completion routing
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign req.valid = busy;
    assign req.ch = grant;
    assign req.cmd = req_cmd;
    assign req.arg0 = req_arg0;
    assign req.arg1 = req_arg1;

    // a done while idle goes nowhere
    always_comb begin
        for (int i = 0; i < cfg_pkg::NUM_CH; i++) begin
            ch_done[i] = busy && rsp.done && (grant == cfg_pkg::CH_BITS'(i));
        end
    end

    assign rsp_fwd.error = rsp.error;
    assign rsp_fwd.irq = rsp.irq;
    assign rsp_fwd.res0 = rsp.res0;
    assign rsp_fwd.res1 = rsp.res1;

endmodule

// ==== cfg_subsystem.sv ====
`timescale 1ns/1ps

module cfg_subsystem (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               host_reset,

    input  cfg_pkg::host_bus_t bus,
    output logic [15:0]        rdata,

    output cfg_pkg::ctrl_req_t ctrl_req,
    input  cfg_pkg::ctrl_rsp_t ctrl_rsp,

    output logic               irq
);

    cfg_pkg::ch_wr_t                 ch_wr [cfg_pkg::NUM_CH];
    cfg_pkg::reg_idx_e               ch_reg;
    logic [15:0]                     ch_rdata [cfg_pkg::NUM_CH];
    cfg_pkg::mbox_cmd_t              offer [cfg_pkg::NUM_CH];
    logic [cfg_pkg::NUM_CH-1:0]      ch_done;
    logic [cfg_pkg::NUM_CH-1:0]      ch_irq;
    cfg_pkg::mbox_rsp_t              rsp_fwd;

    cfg_bus_decode i_decode (
        .bus      (bus),
        .ch_wr    (ch_wr),
        .ch_reg   (ch_reg),
        .ch_rdata (ch_rdata),
        .rdata    (rdata)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // mailbox channels
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    for (genvar i = 0; i < cfg_pkg::NUM_CH; i++) begin : g_ch
        cfg_mailbox i_mailbox (
            .clk        (clk),
            .arst_n     (arst_n),
            .host_reset (host_reset),
            .wr         (ch_wr[i]),
            .rd_reg     (ch_reg),
            .rdata      (ch_rdata[i]),
            .offer      (offer[i]),
            .done       (ch_done[i]),
            .rsp_error  (rsp_fwd.error),
            .rsp_irq    (rsp_fwd.irq),
            .res0       (rsp_fwd.res0),
            .res1       (rsp_fwd.res1),
            .irq        (ch_irq[i])
        );
    end

    cfg_cmd_arbiter i_arbiter (
        .clk        (clk),
        .arst_n     (arst_n),
        .host_reset (host_reset),
        .offer      (offer),
        .ch_done    (ch_done),
        .rsp_fwd    (rsp_fwd),
        .req        (ctrl_req),
        .rsp        (ctrl_rsp)
    );

    // channel flags are registered, so no extra stage here
    assign irq = |ch_irq;

endmodule

// ==== cfg_subsystem_chk.sv ====
`timescale 1ns/1ps

module cfg_subsystem_chk (
    input logic               clk,
    input logic               arst_n,
    input logic               host_reset,
    input cfg_pkg::ctrl_req_t ctrl_req,
    input cfg_pkg::ctrl_rsp_t ctrl_rsp,
    input logic               irq
);

    int   fail_count = 0;
    logic dropped;

    // a request cut short by host reset may still see a late done
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            dropped <= 1'b0;
        end else if (host_reset) begin
            dropped <= 1'b1;
        end else if (ctrl_req.valid) begin
            dropped <= 1'b0;
        end
    end

    req_stable: assert property (@(posedge clk) disable iff (!arst_n)
        ctrl_req.valid && !ctrl_rsp.done && !host_reset |=> ctrl_req.valid && $stable(ctrl_req))
        else begin
            fail_count++;
            $error("controller request changed before done");
        end

    done_with_valid: assert property (@(posedge clk) disable iff (!arst_n)
        ctrl_rsp.done |-> ctrl_req.valid || host_reset || dropped)
        else begin
            fail_count++;
            $error("done arrived with no request outstanding");
        end

    quiet_after_reset: assert property (@(posedge clk)
        $rose(arst_n) |-> !irq && !ctrl_req.valid)
        else begin
            fail_count++;
            $error("irq or request active right after reset");
        end

endmodule

bind cfg_subsystem cfg_subsystem_chk i_chk (
    .clk        (clk),
    .arst_n     (arst_n),
    .host_reset (host_reset),
    .ctrl_req   (ctrl_req),
    .ctrl_rsp   (ctrl_rsp),
    .irq        (irq)
);

// ==== cfg_subsystem_tb.sv ====
`timescale 1ns/1ps

module cfg_subsystem_tb;

    localparam int CLK_PERIOD = 8;
    localparam int CYCLES_PER_STEP = 200;

    localparam logic [31:0] ARG [12] = '{
        32'h1234_5678, 32'h0f0f_00ff, 32'hdead_beef, 32'h0000_1001,
        32'h0bad_f00d, 32'h1111_2222, 32'h8000_0001, 32'h7fff_ffff,
        32'hcafe_0000, 32'h0000_babe, 32'h5555_aaaa, 32'h0123_4567
    };

    typedef enum logic [2:0] {OP_WRITE, OP_READ, OP_IDLE, OP_HRST, OP_HOLD} op_e;

    typedef struct packed {
        op_e               op;
        logic [1:0]        ch;
        cfg_pkg::reg_idx_e rsel;
        logic [15:0]       data;
        logic [15:0]       exp;
    } step_t;

    logic               clk;
    logic               arst_n;
    logic               host_reset;
    cfg_pkg::host_bus_t bus;
    logic [15:0]        rdata;
    cfg_pkg::ctrl_req_t ctrl_req;
    cfg_pkg::ctrl_rsp_t ctrl_rsp;
    logic               irq;

    step_t              steps [$];
    cfg_pkg::ctrl_req_t served [$];
    logic               ctrl_hold;
    logic               ctrl_busy;
    logic               table_ready;
    logic [31:0]        lfsr;

    // requests the controller should see in order, arguments are ARG[n] and ARG[n+1]
    int         exp_ch [9] = '{1, 2, 2, 0, 3, 2, 3, 0, 1};
    logic [7:0] exp_cmd [9] = '{
        8'h05, 8'h83, 8'h04, 8'h42, 8'h41, 8'h10, 8'h52, 8'h11, 8'h21
    };
    int         exp_arg [9] = '{0, 2, 2, 4, 6, 2, 6, 8, 10};

    cfg_subsystem i_dut (
        .clk        (clk),
        .arst_n     (arst_n),
        .host_reset (host_reset),
        .bus        (bus),
        .rdata      (rdata),
        .ctrl_req   (ctrl_req),
        .ctrl_rsp   (ctrl_rsp),
        .irq        (irq)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // helpers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic next_delay(output int d);
        d = 0;
        for (int i = 0; i < 3; i++) begin
            lfsr = lfsr_step(lfsr);
            d = (d << 1) | int'(lfsr[0]);
        end
    endtask

    // channel in bits 5:4, register in bits 3:1
    function automatic logic [15:0] reg_addr(logic [1:0] ch, cfg_pkg::reg_idx_e rsel);
        return {10'd0, ch, rsel, 1'b0};
    endfunction

    task automatic fail_run();
        $display(">>> FAIL");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_value(string name, logic [31:0] got, logic [31:0] exp);
        if (got !== exp) begin
            $display("Error: %s got 0x%h expected 0x%h", name, got, exp);
            fail_run();
        end
    endtask

    task automatic add_step(op_e op, int ch, cfg_pkg::reg_idx_e rsel, logic [15:0] data,
                            logic [15:0] exp);
        steps.push_back(step_t'{op, 2'(ch), rsel, data, exp});
    endtask

    task automatic write_args(int ch, logic [31:0] a0, logic [31:0] a1);
        add_step(OP_WRITE, ch, cfg_pkg::REG_DATA_0_H, a0[31:16], 0);
        add_step(OP_WRITE, ch, cfg_pkg::REG_DATA_0_L, a0[15:0], 0);
        add_step(OP_WRITE, ch, cfg_pkg::REG_DATA_1_H, a1[31:16], 0);
        add_step(OP_WRITE, ch, cfg_pkg::REG_DATA_1_L, a1[15:0], 0);
    endtask

    // controller answers with xor and sum of the two arguments
    task automatic read_results(int ch, logic [31:0] a0, logic [31:0] a1);
        logic [31:0] r0;
        logic [31:0] r1;
        r0 = a0 ^ a1;
        r1 = a0 + a1;
        add_step(OP_READ, ch, cfg_pkg::REG_DATA_0_H, 0, r0[31:16]);
        add_step(OP_READ, ch, cfg_pkg::REG_DATA_0_L, 0, r0[15:0]);
        add_step(OP_READ, ch, cfg_pkg::REG_DATA_1_H, 0, r1[31:16]);
        add_step(OP_READ, ch, cfg_pkg::REG_DATA_1_L, 0, r1[15:0]);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stimulus table
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic build_table();
        for (int c = 0; c < cfg_pkg::NUM_CH; c++) begin
            add_step(OP_READ, c, cfg_pkg::REG_STATUS, 0, 16'h0000);
            add_step(OP_READ, c, cfg_pkg::REG_VERSION_H, 0, cfg_pkg::CFG_VERSION[31:16]);
            add_step(OP_READ, c, cfg_pkg::REG_VERSION_L, 0, cfg_pkg::CFG_VERSION[15:0]);
        end
        add_step(OP_IDLE, 0, cfg_pkg::REG_STATUS, 0, 0);
        write_args(1, ARG[0], ARG[1]);
        add_step(OP_WRITE, 1, cfg_pkg::REG_COMMAND, 16'h0005, 0);
        add_step(OP_READ, 1, cfg_pkg::REG_STATUS, 0, 16'h8000);
        add_step(OP_IDLE, 0, cfg_pkg::REG_STATUS, 0, 0);
        add_step(OP_READ, 1, cfg_pkg::REG_STATUS, 0, 16'h0000);
        read_results(1, ARG[0], ARG[1]);
        // error bit set by cmd bit 7, cleared by the next completion
        write_args(2, ARG[2], ARG[3]);
        add_step(OP_WRITE, 2, cfg_pkg::REG_COMMAND, 16'h0083, 0);
        add_step(OP_IDLE, 0, cfg_pkg::REG_STATUS, 0, 0);
        add_step(OP_READ, 2, cfg_pkg::REG_STATUS, 0, 16'h4000);
        add_step(OP_WRITE, 2, cfg_pkg::REG_COMMAND, 16'h0004, 0);
        add_step(OP_IDLE, 0, cfg_pkg::REG_STATUS, 0, 0);
        add_step(OP_READ, 2, cfg_pkg::REG_STATUS, 0, 16'h0000);
        // irq from cmd bit 6, cleared per channel by version-low
        write_args(0, ARG[4], ARG[5]);
        add_step(OP_WRITE, 0, cfg_pkg::REG_COMMAND, 16'h0042, 0);
        add_step(OP_IDLE, 0, cfg_pkg::REG_STATUS, 0, 1);
        write_args(3, ARG[6], ARG[7]);
        add_step(OP_WRITE, 3, cfg_pkg::REG_COMMAND, 16'h0041, 0);
        add_step(OP_IDLE, 0, cfg_pkg::REG_STATUS, 0, 1);
        add_step(OP_WRITE, 0, cfg_pkg::REG_VERSION_L, 16'h0000, 0);
        add_step(OP_IDLE, 0, cfg_pkg::REG_STATUS, 0, 1);
        add_step(OP_WRITE, 3, cfg_pkg::REG_VERSION_L, 16'h0000, 0);
        add_step(OP_IDLE, 0, cfg_pkg::REG_STATUS, 0, 0);
        // three channels pending at once, last grant was 3
        write_args(0, ARG[8], ARG[9]);
        add_step(OP_WRITE, 2, cfg_pkg::REG_COMMAND, 16'h0010, 0);
        add_step(OP_WRITE, 0, cfg_pkg::REG_COMMAND, 16'h0011, 0);
        add_step(OP_WRITE, 3, cfg_pkg::REG_COMMAND, 16'h0052, 0);
        add_step(OP_IDLE, 0, cfg_pkg::REG_STATUS, 0, 1);
        read_results(2, ARG[2], ARG[3]);
        read_results(0, ARG[8], ARG[9]);
        read_results(3, ARG[6], ARG[7]);
        // host reset with a request outstanding, its late done must be ignored
        add_step(OP_HOLD, 0, cfg_pkg::REG_STATUS, 16'h0001, 0);
        write_args(1, ARG[10], ARG[11]);
        add_step(OP_WRITE, 1, cfg_pkg::REG_COMMAND, 16'h00e0, 0);
        add_step(OP_READ, 1, cfg_pkg::REG_STATUS, 0, 16'h8000);
        add_step(OP_HRST, 0, cfg_pkg::REG_STATUS, 0, 0);
        add_step(OP_HOLD, 0, cfg_pkg::REG_STATUS, 16'h0000, 0);
        add_step(OP_IDLE, 0, cfg_pkg::REG_STATUS, 0, 0);
        add_step(OP_READ, 1, cfg_pkg::REG_STATUS, 0, 16'h0000);
        add_step(OP_READ, 1, cfg_pkg::REG_COMMAND, 0, 16'h0000);
        read_results(1, ARG[0], ARG[1]);
        add_step(OP_WRITE, 1, cfg_pkg::REG_COMMAND, 16'h0021, 0);
        add_step(OP_IDLE, 0, cfg_pkg::REG_STATUS, 0, 0);
        read_results(1, ARG[10], ARG[11]);
    endtask

    // polls one status register per cycle plus the controller until all is quiet
    task automatic wait_idle();
        logic [cfg_pkg::NUM_CH-1:0] quiet;
        int                         c;
        logic                       idle;
        quiet = '0;
        c = 0;
        idle = 1'b0;
        while (!idle) begin
            bus.address = reg_addr(2'(c), cfg_pkg::REG_STATUS);
            @(negedge clk);
            if (!rdata[15]) begin
                quiet[c] = 1'b1;
            end
            idle = (&quiet) && !ctrl_req.valid && !ctrl_busy;
            if (!idle) begin
                c = (c + 1) % cfg_pkg::NUM_CH;
                @(posedge clk);
                #1;
            end
        end
    endtask

    task automatic apply_step(step_t s);
        @(posedge clk);
        #1;
        bus.write = 1'b0;
        host_reset = 1'b0;
        case (s.op)
            OP_WRITE: begin
                bus.address = reg_addr(s.ch, s.rsel);
                bus.wdata = s.data;
                bus.write = 1'b1;
            end
            OP_READ: begin
                bus.address = reg_addr(s.ch, s.rsel);
                @(negedge clk);
                check_value($sformatf("rdata ch%0d %s", s.ch, s.rsel.name()), rdata, s.exp);
            end
            OP_IDLE: begin
                wait_idle();
                check_value("irq", irq, s.exp);
            end
            OP_HRST: host_reset = 1'b1;
            OP_HOLD: ctrl_hold = s.data[0];
            default: ;
        endcase
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // processes
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // controller model, answers after a random 0 to 7 cycles
    initial begin
        int                 delay;
        cfg_pkg::ctrl_req_t req;
        ctrl_rsp = '0;
        ctrl_busy = 1'b0;
        forever begin
            @(posedge clk);
            #1;
            if (ctrl_req.valid) begin
                ctrl_busy = 1'b1;
                req = ctrl_req;
                while (ctrl_hold) begin
                    @(posedge clk);
                    #1;
                end
                next_delay(delay);
                repeat (delay) begin
                    @(posedge clk);
                    #1;
                end
                // a request dropped by host reset still gets a late done
                if (ctrl_req.valid) begin
                    served.push_back(req);
                end
                ctrl_rsp.error = req.cmd[7];
                ctrl_rsp.irq = req.cmd[6];
                ctrl_rsp.res0 = req.arg0 ^ req.arg1;
                ctrl_rsp.res1 = req.arg0 + req.arg1;
                ctrl_rsp.done = 1'b1;
                @(posedge clk);
                #1;
                ctrl_rsp.done = 1'b0;
                ctrl_busy = 1'b0;
            end
        end
    end

    initial begin
        wait (table_ready);
        #(CLK_PERIOD * CYCLES_PER_STEP * (steps.size() + 3));
        $display("timeout: the table did not complete within its cycle budget");
        fail_run();
    end

    initial begin
        wait (i_dut.i_chk.fail_count != 0);
        $display("an assertion in the bound checker failed");
        fail_run();
    end

    initial begin
        bus = '0;
        host_reset = 1'b0;
        arst_n = 1'b0;
        ctrl_hold = 1'b0;
        lfsr = 32'hf083_0319;
        table_ready = 1'b0;
        build_table();
        table_ready = 1'b1;
        repeat (3) @(posedge clk);
        #1;
        arst_n = 1'b1;
        foreach (steps[i]) begin
            apply_step(steps[i]);
        end
        @(posedge clk);
        #1;
        bus.write = 1'b0;
        host_reset = 1'b0;
        check_value("served count", served.size(), $size(exp_ch));
        foreach (exp_ch[i]) begin
            check_value($sformatf("ctrl_req.ch[%0d]", i), served[i].ch, exp_ch[i]);
            check_value($sformatf("ctrl_req.cmd[%0d]", i), served[i].cmd, exp_cmd[i]);
            check_value($sformatf("ctrl_req.arg0[%0d]", i), served[i].arg0, ARG[exp_arg[i]]);
            check_value($sformatf("ctrl_req.arg1[%0d]", i), served[i].arg1,
                        ARG[exp_arg[i] + 1]);
        end
        if (i_dut.i_chk.fail_count == 0) begin
            $display(">>> PASS");
            $finish;
        end else begin
            $display("%0d assertion failures were reported", i_dut.i_chk.fail_count);
            fail_run();
        end
    end

endmodule

// ==== cfg_subsystem.f ====
cfg_pkg.sv
cfg_bus_decode.sv
cfg_mailbox.sv
cfg_cmd_arbiter.sv
cfg_subsystem.sv
cfg_subsystem_chk.sv
cfg_subsystem_tb.sv
